/* design/mul_pkg.sv */
`default_nettype none

package mul_pkg;

	localparam int XLEN   = 64;
	localparam int OPND_W = XLEN + 2;     // Two guard bits keep unsigned values positive.
	localparam int PROD_W = 2 * XLEN + 2;

	typedef logic [XLEN-1:0]   xlen_t;
	typedef logic [OPND_W-1:0] opnd_t;
	typedef logic [PROD_W-1:0] prod_t;

	typedef enum logic [2:0] {
		MUL_LO  = 3'd0, // MUL.
		MUL_HSS = 3'd1, // MULH.
		MUL_HSU = 3'd2, // MULHSU.
		MUL_HUU = 3'd3, // MULHU.
		MUL_W   = 3'd4  // MULW.
	} mul_op_e;

	typedef enum logic [1:0] {
		BOOTH_IDLE  = 2'd0,
		BOOTH_FIRST = 2'd1,
		BOOTH_STEP  = 2'd2,
		BOOTH_LAST  = 2'd3
	} booth_state_e;

	// Request as presented by the pipeline.
	typedef struct packed {
		mul_op_e op;
		xlen_t   rs1;
		xlen_t   rs2;
	} mul_req_t;

	typedef struct packed {
		opnd_t multiplicand;
		opnd_t multiplier;
		logic  take_high;   // Upper half of the product.
		logic  word;        // Sign-extended low word.
	} mul_opnd_t;

endpackage

`default_nettype wire

/* design/mul_operand_prep.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_operand_prep (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               mul_valid,
	input  mul_pkg::mul_req_t  mul_req,
	input  logic               core_idle,
	output logic               start,
	output mul_pkg::mul_opnd_t opnd
);

	logic               accept;
	logic               src1_signed;
	logic               src2_signed;
	mul_pkg::xlen_t     src1;
	mul_pkg::xlen_t     src2;
	mul_pkg::mul_opnd_t opnd_d;

	assign accept = mul_valid & core_idle;

	// MULW only looks at the low words.
	always_comb begin
		if (mul_req.op == mul_pkg::MUL_W) begin
			src1 = {{32{mul_req.rs1[31]}}, mul_req.rs1[31:0]};
			src2 = {{32{mul_req.rs2[31]}}, mul_req.rs2[31:0]};
		end else begin
			src1 = mul_req.rs1;
			src2 = mul_req.rs2;
		end
	end

	always_comb begin
		case (mul_req.op)
			mul_pkg::MUL_HSU: begin
				src1_signed = 1'b1;
				src2_signed = 1'b0;
			end
			mul_pkg::MUL_HUU: begin
				src1_signed = 1'b0;
				src2_signed = 1'b0;
			end
			default: begin      // Low half does not depend on signedness.
				src1_signed = 1'b1;
				src2_signed = 1'b1;
			end
		endcase
	end

	assign opnd_d.multiplicand = {{2{src1_signed & src1[mul_pkg::XLEN-1]}}, src1};
	assign opnd_d.multiplier   = {{2{src2_signed & src2[mul_pkg::XLEN-1]}}, src2};
	assign opnd_d.take_high    = mul_req.op inside {mul_pkg::MUL_HSS, mul_pkg::MUL_HSU,
		mul_pkg::MUL_HUU};
	assign opnd_d.word         = (mul_req.op == mul_pkg::MUL_W);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start <= 1'b0;
		end else begin
			start <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) opnd <= opnd_d;
	end

endmodule

`default_nettype wire

/* design/booth_radix4_core.sv */
`timescale 1ns/1ps
`default_nettype none

module booth_radix4_core (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           start,
	input  logic           mul_valid,
	input  mul_pkg::opnd_t multiplicand,
	input  mul_pkg::opnd_t multiplier,
	output logic           core_idle,
	output mul_pkg::prod_t product,
	output logic           prod_done,
	output logic           mul_stall
);

	localparam int EXT_W = mul_pkg::PROD_W - mul_pkg::OPND_W;

	mul_pkg::booth_state_e state;
	mul_pkg::booth_state_e state_nxt;

	mul_pkg::prod_t acc;      // Running product.
	mul_pkg::prod_t mcand;    // Multiplicand, weighted by the current digit position.
	mul_pkg::prod_t pp;

	// Multiplier with the implicit zero appended below bit 0.
	logic [mul_pkg::OPND_W:0] mrem;
	logic [mul_pkg::OPND_W:0] mrem_nxt;

	logic rest_const;
	logic done_q;

	// Next triplet window, arithmetic shift by one digit.
	assign mrem_nxt = {{2{mrem[mul_pkg::OPND_W]}}, mrem[mul_pkg::OPND_W:2]};

	// Everything above the next triplet is sign only, so that digit is the last one.
	assign rest_const = (&mrem_nxt[mul_pkg::OPND_W:2]) | ~(|mrem_nxt[mul_pkg::OPND_W:2]);

	// Radix-4 digit from the low triplet.
	always_comb begin
		case (mrem[2:0])
			3'b001, 3'b010: pp = mcand;                     // +1.
			3'b011:         pp = mcand << 1;                // +2.
			3'b100:         pp = ~(mcand << 1) + 1'b1;      // -2.
			3'b101, 3'b110: pp = ~mcand + 1'b1;             // -1.
			default:        pp = '0;
		endcase
	end

	always_comb begin
		state_nxt = state;
		case (state)
			mul_pkg::BOOTH_IDLE: begin
				if (start) state_nxt = mul_pkg::BOOTH_FIRST;
			end
			mul_pkg::BOOTH_FIRST,
			mul_pkg::BOOTH_STEP: begin
				if (rest_const) begin
					state_nxt = mul_pkg::BOOTH_LAST;
				end else begin
					state_nxt = mul_pkg::BOOTH_STEP;
				end
			end
			mul_pkg::BOOTH_LAST: begin
				state_nxt = mul_pkg::BOOTH_IDLE;
			end
			default: begin
				state_nxt = mul_pkg::BOOTH_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mul_pkg::BOOTH_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			mul_pkg::BOOTH_IDLE: begin
				if (start) begin
					mcand <= {{EXT_W{multiplicand[mul_pkg::OPND_W-1]}}, multiplicand};
					mrem  <= {multiplier, 1'b0};
				end
			end
			mul_pkg::BOOTH_FIRST: begin
				acc   <= pp;    // First digit seeds the accumulator.
				mcand <= mcand << 2;
				mrem  <= mrem_nxt;
			end
			default: begin
				acc   <= acc + pp;
				mcand <= mcand << 2;
				mrem  <= mrem_nxt;
			end
		endcase
	end

	// prod_done comes with the final sum, done_q lines up with the result register.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prod_done <= 1'b0;
			done_q    <= 1'b0;
		end else begin
			prod_done <= (state == mul_pkg::BOOTH_LAST);
			done_q    <= prod_done;
		end
	end

	assign product = acc;

	// Idle only once the previous result has gone out, so a held request is not taken twice.
	assign core_idle = (state == mul_pkg::BOOTH_IDLE) & ~start & ~prod_done & ~done_q;

	assign mul_stall = mul_valid & ~done_q;

endmodule

`default_nettype wire

/* design/mul_result_sel.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_result_sel (
	input  logic           clk,
	input  logic           rst_n,
	input  mul_pkg::prod_t product,
	input  logic           prod_done,
	input  logic           take_high,
	input  logic           word,
	output mul_pkg::xlen_t mul_result,
	output logic           mul_done
);

	mul_pkg::xlen_t res_d;
	mul_pkg::xlen_t prod_lo;
	mul_pkg::xlen_t prod_hi;

	assign prod_lo = product[mul_pkg::XLEN-1:0];
	assign prod_hi = product[2*mul_pkg::XLEN-1:mul_pkg::XLEN];

	always_comb begin
		if (word) begin
			res_d = {{32{prod_lo[31]}}, prod_lo[31:0]};  // MULW.
		end else if (take_high) begin
			res_d = prod_hi;
		end else begin
			res_d = prod_lo;
		end
	end

	// Held until the next product arrives.
	always_ff @(posedge clk) begin
		if (prod_done) mul_result <= res_d;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mul_done <= 1'b0;
		end else begin
			mul_done <= prod_done;
		end
	end

endmodule

`default_nettype wire

/* design/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              mul_valid,
	input  mul_pkg::mul_req_t mul_req,
	output logic              mul_stall,
	output logic              mul_done,
	output mul_pkg::xlen_t    mul_result
);

	mul_pkg::mul_opnd_t opnd;
	mul_pkg::prod_t     product;
	logic               start;
	logic               core_idle;
	logic               prod_done;

	mul_operand_prep u_operand_prep (
		.clk       (clk),
		.rst_n     (rst_n),
		.mul_valid (mul_valid),
		.mul_req   (mul_req),
		.core_idle (core_idle),
		.start     (start),
		.opnd      (opnd)
	);

	booth_radix4_core u_booth_core (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.mul_valid    (mul_valid),
		.multiplicand (opnd.multiplicand),
		.multiplier   (opnd.multiplier),
		.core_idle    (core_idle),
		.product      (product),
		.prod_done    (prod_done),
		.mul_stall    (mul_stall)
	);

	mul_result_sel u_result_sel (
		.clk        (clk),
		.rst_n      (rst_n),
		.product    (product),
		.prod_done  (prod_done),
		.take_high  (opnd.take_high),
		.word       (opnd.word),
		.mul_result (mul_result),
		.mul_done   (mul_done)
	);

endmodule

`default_nettype wire

/* testbench/tb_mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mul_unit;

	localparam int NUM_VEC     = 52;
	localparam int NUM_RANDOM  = 40;
	localparam int TIMEOUT_CYC = 60;

	logic              clk;
	logic              rst_n;
	logic              mul_valid;
	mul_pkg::mul_req_t mul_req;
	logic              mul_stall;
	logic              mul_done;
	mul_pkg::xlen_t    mul_result;

	logic [63:0] vec_mem [0:4*NUM_VEC-1];   // Four words per vector.
	integer      seed;

	mul_unit u_mul_unit (
		.clk        (clk),
		.rst_n      (rst_n),
		.mul_valid  (mul_valid),
		.mul_req    (mul_req),
		.mul_stall  (mul_stall),
		.mul_done   (mul_done),
		.mul_result (mul_result)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic string op_name(input logic [2:0] op);
		case (op)
			3'd0:    return "MUL";
			3'd1:    return "MULH";
			3'd2:    return "MULHSU";
			3'd3:    return "MULHU";
			3'd4:    return "MULW";
			default: return "UNKNOWN";
		endcase
	endfunction

	// Reference for the random cases, both operands taken as unsigned.
	function automatic mul_pkg::xlen_t unsigned_product_half(input logic high,
		input mul_pkg::xlen_t a, input mul_pkg::xlen_t b);
		logic [127:0] full;
		full = {64'd0, a} * {64'd0, b};
		return high ? full[127:64] : full[63:0];
	endfunction

	task automatic abort_run();
		$display("tests failed");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_result(input logic [2:0] op, input mul_pkg::xlen_t rs1,
		input mul_pkg::xlen_t rs2, input mul_pkg::xlen_t expected);
		assert (mul_result === expected) else begin
			$display("[FAIL] %0t ns: %s rs1=%h rs2=%h expected %h got %h",
				$time, op_name(op), rs1, rs2, expected, mul_result);
			abort_run();
		end
	endtask

	// Called on a falling edge with the request already driven.
	task automatic wait_for_done(input logic [2:0] op);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			assert (!(mul_done && cycles == 1)) else begin
				$display("mul_done pulsed one cycle after a %s request was presented",
					op_name(op));
				abort_run();
			end
			if (!mul_done) begin
				assert (mul_stall) else begin
					$display("mul_stall went low at %0t ns with a %s request still pending",
						$time, op_name(op));
					abort_run();
				end
				if (cycles >= TIMEOUT_CYC) begin
					$display("mul_done never arrived within %0d cycles for a %s request",
						TIMEOUT_CYC, op_name(op));
					abort_run();
				end
			end
		end while (!mul_done);
		assert (!mul_stall) else begin
			$display("mul_stall was still high in the mul_done cycle at %0t ns", $time);
			abort_run();
		end
	endtask

	// gap of zero keeps mul_valid high, so the next request follows back to back.
	task automatic run_case(input logic [2:0] op, input mul_pkg::xlen_t rs1,
		input mul_pkg::xlen_t rs2, input mul_pkg::xlen_t expected, input int gap);
		mul_valid   = 1'b1;
		mul_req.op  = mul_pkg::mul_op_e'(op);
		mul_req.rs1 = rs1;
		mul_req.rs2 = rs2;
		wait_for_done(op);
		check_result(op, rs1, rs2, expected);
		if (gap > 0) begin
			mul_valid = 1'b0;
			repeat (gap) begin
				@(negedge clk);
				assert (!mul_done && !mul_stall) else begin
					$display("mul_done or mul_stall was high at %0t ns with no request",
						$time);
					abort_run();
				end
				check_result(op, rs1, rs2, expected);  // Result must be held.
			end
		end
	endtask

	initial begin
		logic [2:0]     op;
		mul_pkg::xlen_t a;
		mul_pkg::xlen_t b;
		mul_pkg::xlen_t exp_val;
		logic [31:0]    rnd;

		seed      = 55;
		rst_n     = 1'b0;
		mul_valid = 1'b0;
		mul_req   = '0;

		$readmemh("testbench/mul_testdata.hex", vec_mem);
		assert (vec_mem[4*NUM_VEC-1] !== 'x) else begin
			$display("testbench/mul_testdata.hex holds fewer vectors than expected");
			abort_run();
		end

		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Quiet outputs before the first request.
		repeat (3) begin
			@(negedge clk);
			assert (!mul_stall && !mul_done) else begin
				$display("mul_stall or mul_done was high after reset with no request");
				abort_run();
			end
		end

		for (int i = 0; i < NUM_VEC; i++) begin
			op = vec_mem[4*i][2:0];
			run_case(op, vec_mem[4*i+1], vec_mem[4*i+2], vec_mem[4*i+3],
				(i % 4 == 3) ? 2 : 0);
		end

		for (int i = 0; i < NUM_RANDOM; i++) begin
			a[63:32] = $random(seed);
			a[31:0]  = $random(seed);
			b[63:32] = $random(seed);
			b[31:0]  = $random(seed);
			rnd      = $random(seed);
			if (rnd[1:0] == 2'd0) b = b >> rnd[7:2];  // Short multipliers end early.
			op      = rnd[8] ? 3'd3 : 3'd0;
			exp_val = unsigned_product_half(rnd[8], a, b);
			run_case(op, a, b, exp_val, int'(rnd[10:9]));
		end

		mul_valid = 1'b0;
		@(negedge clk);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
design/mul_pkg.sv
design/mul_operand_prep.sv
design/booth_radix4_core.sv
design/mul_result_sel.sv
design/mul_unit.sv
testbench/tb_mul_unit.sv

/* Bender.yml */
package:
  name: mul_unit

dependencies: {}

sources:
  # Package first, then the leaf modules and the top level.
  - files:
      - design/mul_pkg.sv
      - design/mul_operand_prep.sv
      - design/booth_radix4_core.sv
      - design/mul_result_sel.sv
      - design/mul_unit.sv

  # Self-checking testbench, reads testbench/mul_testdata.hex at run time.
  - target: test
    files:
      - testbench/tb_mul_unit.sv

/* testbench/mul_testdata.hex */
// Each line holds op, rs1, rs2 and the expected result in hex.
// Op codes 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU, 4 MULW.
// MUL edge values.
0 0000000000000000 0000000000000000 0000000000000000
0 0000000000000001 0000000000000001 0000000000000001
0 0000000000000000 FFFFFFFFFFFFFFFF 0000000000000000
0 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0000000000000001
0 8000000000000000 FFFFFFFFFFFFFFFF 8000000000000000
0 8000000000000000 8000000000000000 0000000000000000
0 0000000000000003 0000000000000005 000000000000000F
0 FFFFFFFFFFFFFFFF 0000000000000002 FFFFFFFFFFFFFFFE
0 0000000100000000 0000000100000000 0000000000000000
0 123456789ABCDEF0 0000000000000001 123456789ABCDEF0
0 0000000000000010 123456789ABCDEF0 23456789ABCDEF00
0 7FFFFFFFFFFFFFFF 0000000000000002 FFFFFFFFFFFFFFFE
0 00000000FFFFFFFF 00000000FFFFFFFF FFFFFFFE00000001
// MULH, signed by signed.
1 0000000000000000 FFFFFFFFFFFFFFFF 0000000000000000
1 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0000000000000000
1 8000000000000000 FFFFFFFFFFFFFFFF 0000000000000000
1 8000000000000000 8000000000000000 4000000000000000
1 FFFFFFFFFFFFFFFF 0000000000000002 FFFFFFFFFFFFFFFF
1 8000000000000000 0000000000000001 FFFFFFFFFFFFFFFF
1 7FFFFFFFFFFFFFFF 7FFFFFFFFFFFFFFF 3FFFFFFFFFFFFFFF
1 8000000000000000 7FFFFFFFFFFFFFFF C000000000000000
1 0000000100000000 0000000100000000 0000000000000001
// MULHSU, signed rs1 by unsigned rs2.
2 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
2 8000000000000000 FFFFFFFFFFFFFFFF 8000000000000000
2 0000000000000001 FFFFFFFFFFFFFFFF 0000000000000000
2 FFFFFFFFFFFFFFFF 0000000000000001 FFFFFFFFFFFFFFFF
2 FFFFFFFFFFFFFFFF 0000000000000002 FFFFFFFFFFFFFFFF
2 0000000000000002 8000000000000000 0000000000000001
2 FFFFFFFFFFFFFFFF 0000000000000000 0000000000000000
2 7FFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 7FFFFFFFFFFFFFFE
// MULHU, unsigned by unsigned.
3 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFE
3 8000000000000000 FFFFFFFFFFFFFFFF 7FFFFFFFFFFFFFFF
3 8000000000000000 8000000000000000 4000000000000000
3 8000000000000000 0000000000000002 0000000000000001
3 FFFFFFFFFFFFFFFF 0000000000000002 0000000000000001
3 0000000000000001 FFFFFFFFFFFFFFFF 0000000000000000
3 0000000000000000 FFFFFFFFFFFFFFFF 0000000000000000
3 0000000100000000 FFFFFFFFFFFFFFFF 00000000FFFFFFFF
// MULW with junk in the upper source bits.
4 DEADBEEF00000003 CAFEBABE00000005 000000000000000F
4 12345678FFFFFFFF 87654321FFFFFFFF 0000000000000001
4 ABCDEF0100000002 5555555580000000 0000000000000000
4 FFFFFFFF7FFFFFFF 0000000000000002 FFFFFFFFFFFFFFFE
4 1111111100010000 2222222200010000 0000000000000000
4 0000000000001000 AAAAAAAA00080000 FFFFFFFF80000000
4 7777777712345678 9999999900000010 0000000023456780
4 00000001FFFFFFFE 0000000300000003 FFFFFFFFFFFFFFFA
// Small operands, short latency.
0 0000000000000000 0000000000000007 0000000000000000
0 0000000000000007 0000000000000000 0000000000000000
0 0000000000000002 0000000000000003 0000000000000006
0 FFFFFFFFFFFFFFFD FFFFFFFFFFFFFFFB 000000000000000F
1 FFFFFFFFFFFFFFFD FFFFFFFFFFFFFFFB 0000000000000000
0 0000000000000064 0000000000000064 0000000000002710
